// ==== hw/axi_sub_pkg.sv ====
package axi_sub_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;
  localparam int LEN_W  = 8;
  localparam int SIZE_W = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   axi_id_t;
  typedef logic [1:0]        resp_t;

  // SRAM window, 1 KiB
  localparam addr_t MEM_BASE  = 32'h0000_1000;
  localparam int    MEM_WORDS = 256;

  localparam int TIMEOUT_CYCLES = 16;

  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam resp_t      RESP_OKAY  = 2'b00;

  typedef struct packed {
    axi_id_t           id;
    addr_t             addr;
    logic [LEN_W-1:0]  len;
    logic [SIZE_W-1:0] size;
    logic [1:0]        burst;
  } axi_ax_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t id;
    resp_t   resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } axi_r_t;

  typedef enum logic [2:0] {IDLE, AR, R, AW, W, B} master_state_t;

endpackage

// ==== hw/bus_timer.sv ====
module bus_timer
  import axi_sub_pkg::*;
(
  input  logic clk,
  input  logic rstn,
  input  logic restart,
  input  logic run,
  output logic expired
);

  logic [$clog2(TIMEOUT_CYCLES+1)-1:0] count;

  // Saturates at the limit until the next restart
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      count <= '0;
    end else if (restart) begin
      count <= '0;
    end else if (run && !expired) begin
      count <= count + 1'b1;
    end
  end

  assign expired = (count == TIMEOUT_CYCLES);

  // Expiry only shows up while a phase is running
  a_expire_after_run: assert property (
    @(posedge clk) disable iff (!rstn)
    $rose(expired) |-> run
  );

endmodule

// ==== hw/axi_master.sv ====
module axi_master
  import axi_sub_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  logic    read,
  input  logic    write,
  input  addr_t   addr,
  input  data_t   wdata,
  input  strb_t   wstrb,
  output data_t   data_out,
  output logic    stall,
  output logic    bus_err,
  output axi_ax_t aw,
  output logic    aw_valid,
  input  logic    aw_ready,
  output axi_w_t  w,
  output logic    w_valid,
  input  logic    w_ready,
  input  axi_b_t  b,
  input  logic    b_valid,
  output logic    b_ready,
  output axi_ax_t ar,
  output logic    ar_valid,
  input  logic    ar_ready,
  input  axi_r_t  r,
  input  logic    r_valid,
  output logic    r_ready
);

  master_state_t state, step_state, next_state;
  logic aw_hs, w_hs, b_hs, ar_hs, r_hs;
  logic w_sent;
  logic done, resp_err, expired, abort, rd_abort;
  axi_ax_t ax_req;
  data_t rdata_q;

  assign aw_hs = aw_valid & aw_ready;
  assign w_hs  = w_valid & w_ready;
  assign b_hs  = b_valid & b_ready;
  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;

  always_comb begin
    step_state = state;
    case (state)
      IDLE: begin
        if (write) begin
          step_state = AW;
        end else if (read) begin
          step_state = AR;
        end
      end
      AW: if (aw_hs) step_state = (w_hs || w_sent) ? B : W;
      W:  if (w_hs) step_state = B;
      B:  if (b_hs) step_state = IDLE;
      AR: if (ar_hs) step_state = R;
      R:  if (r_hs) step_state = IDLE;
      default: step_state = IDLE;
    endcase
  end

  // Give up only on a phase that made no progress
  assign abort      = expired && (step_state == state);
  assign next_state = abort ? IDLE : step_state;
  assign rd_abort   = abort && (state == AR || state == R);

  assign done     = b_hs || r_hs;
  assign resp_err = (b_hs && b.resp != RESP_OKAY) || (r_hs && r.resp != RESP_OKAY);
  assign stall    = (read || write) && !done && !abort;
  assign bus_err  = abort || resp_err;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state  <= IDLE;
      w_sent <= 1'b0;
    end else begin
      state <= next_state;
      if (next_state != state) begin
        w_sent <= 1'b0;
      end else if (w_hs) begin
        w_sent <= 1'b1;
      end
    end
  end

  // Last read word, cleared by an abandoned read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_q <= '0;
    end else if (r_hs) begin
      rdata_q <= r.data;
    end else if (rd_abort) begin
      rdata_q <= '0;
    end
  end

  assign data_out = r_hs ? r.data : (rd_abort ? '0 : rdata_q);

  // Single beat, full width
  assign ax_req = '{id: '0, addr: addr, len: '0,
                    size: SIZE_W'($clog2(STRB_W)), burst: BURST_INCR};

  assign aw       = ax_req;
  assign ar       = ax_req;
  assign w        = '{data: wdata, strb: wstrb, last: 1'b1};
  assign aw_valid = (state == AW);
  assign w_valid  = (state == AW && !w_sent) || (state == W);
  assign b_ready  = (state == B);
  assign ar_valid = (state == AR);
  assign r_ready  = (state == R);

  bus_timer u_timer (
    .clk     (clk),
    .rstn    (rstn),
    .restart (next_state != state),
    .run     (state != IDLE),
    .expired (expired)
  );

  // Relies on the CPU holding its request while stalled
  a_aw_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    aw_valid && !aw_ready && !abort |=> aw_valid && $stable(aw)
  );

  // An error pulse ends a pending request
  a_no_stall_err: assert property (
    @(posedge clk) disable iff (!rstn)
    bus_err |-> (read || write) && !stall
  );

endmodule

// ==== hw/sram_slave.sv ====
module sram_slave
  import axi_sub_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  axi_ax_t aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_w_t  w,
  input  logic    w_valid,
  output logic    w_ready,
  output axi_b_t  b,
  output logic    b_valid,
  input  logic    b_ready,
  input  axi_ax_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready
);

  data_t mem [MEM_WORDS];
  logic [$clog2(MEM_WORDS)-1:0] wr_idx;
  logic wr_busy, rd_busy;
  logic aw_hs, w_hs, b_hs, ar_hs, r_hs;
  data_t rdata;

  function automatic logic in_window(addr_t a);
    return (a >= MEM_BASE) && ((a - MEM_BASE) < addr_t'(MEM_WORDS * STRB_W));
  endfunction

  function automatic logic [$clog2(MEM_WORDS)-1:0] word_idx(addr_t a);
    addr_t off;
    off = a - MEM_BASE;
    return off[$clog2(STRB_W) +: $clog2(MEM_WORDS)];
  endfunction

  assign aw_hs = aw_valid & aw_ready;
  assign w_hs  = w_valid & w_ready;
  assign b_hs  = b_valid & b_ready;
  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;

  // Write phase, one transaction at a time
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      b_valid  <= 1'b0;
      wr_busy  <= 1'b0;
    end else begin
      aw_ready <= aw_valid && !aw_ready && !wr_busy && in_window(aw.addr);
      if (aw_hs) begin
        wr_busy <= 1'b1;
        w_ready <= 1'b1;
      end
      if (w_hs) begin
        w_ready <= 1'b0;
        b_valid <= 1'b1;
      end
      if (b_hs) begin
        b_valid <= 1'b0;
        wr_busy <= 1'b0;
      end
    end
  end

  // Read phase, data held until taken
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ar_ready <= 1'b0;
      rd_busy  <= 1'b0;
    end else begin
      ar_ready <= ar_valid && !ar_ready && !rd_busy && in_window(ar.addr);
      if (ar_hs) begin
        rd_busy <= 1'b1;
      end else if (r_hs) begin
        rd_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_idx <= word_idx(aw.addr);
    end
    if (w_hs) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (w.strb[i]) mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
      end
    end
    if (ar_hs) begin
      rdata <= mem[word_idx(ar.addr)];
    end
  end

  assign b       = '{id: '0, resp: RESP_OKAY};
  assign r       = '{id: '0, data: rdata, resp: RESP_OKAY, last: 1'b1};
  assign r_valid = rd_busy;

  a_b_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    b_valid && !b_ready |=> b_valid
  );

endmodule

// ==== hw/axi_sub_top.sv ====
module axi_sub_top
  import axi_sub_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  logic  read,
  input  logic  write,
  input  addr_t addr,
  input  data_t wdata,
  input  strb_t wstrb,
  output data_t data_out,
  output logic  stall,
  output logic  bus_err
);

  axi_ax_t aw, ar;
  axi_w_t  w;
  axi_b_t  b;
  axi_r_t  r;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;

  axi_master u_master (
    .clk (clk), .rstn (rstn),
    .read (read), .write (write), .addr (addr), .wdata (wdata), .wstrb (wstrb),
    .data_out (data_out), .stall (stall), .bus_err (bus_err),
    .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w (w), .w_valid (w_valid), .w_ready (w_ready),
    .b (b), .b_valid (b_valid), .b_ready (b_ready),
    .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r (r), .r_valid (r_valid), .r_ready (r_ready)
  );

  sram_slave u_sram (
    .clk (clk), .rstn (rstn),
    .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w (w), .w_valid (w_valid), .w_ready (w_ready),
    .b (b), .b_valid (b_valid), .b_ready (b_ready),
    .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r (r), .r_valid (r_valid), .r_ready (r_ready)
  );

endmodule

// ==== dv/tb_checker.sv ====
module tb_checker
  import axi_sub_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  logic  read,
  input  logic  write,
  input  logic  stall,
  input  logic  bus_err,
  input  data_t data_out,
  input  data_t exp_data,
  input  logic  exp_err,
  input  int    req_num,
  output int    error_count,
  output int    check_count
);

  initial begin
    error_count = 0;
    check_count = 0;
  end

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s request %0d at %0t expected 0x%h got 0x%h",
               name, req_num, $time, expected, actual);
    end
  endtask

  task automatic compare_word(input string name, input data_t expected, input data_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s request %0d at %0t expected 0x%h got 0x%h",
               name, req_num, $time, expected, actual);
    end
  endtask

  // Values seen at the edge are the ones settled during the cycle before it
  always @(posedge clk) begin
    if (rstn) begin
      if (read || write) begin
        if (!stall) begin
          compare_bit("bus_err", exp_err, bus_err);
          compare_word("data_out", exp_data, data_out);
        end
      end else begin
        // Quiet bus, data_out keeps the last read word
        compare_bit("stall", 1'b0, stall);
        compare_bit("bus_err", 1'b0, bus_err);
        compare_word("data_out", exp_data, data_out);
      end
    end
  end

endmodule

// ==== dv/tb_top.sv ====
module tb_top
  import axi_sub_pkg::*;
;

  localparam int    CLK_HALF       = 10;
  localparam int    DRIVE_DELAY    = 2;
  localparam int    RESET_CYCLES   = 4;
  localparam int    CYCLES_PER_REQ = 2 * TIMEOUT_CYCLES + 10;
  localparam string STIM_FILE      = "dv/axi_stimulus.txt";

  logic  clk;
  logic  rstn;
  logic  read;
  logic  write;
  addr_t addr;
  data_t wdata;
  strb_t wstrb;
  data_t data_out;
  logic  stall;
  logic  bus_err;

  data_t exp_data;
  logic  exp_err;
  int    req_num;
  int    error_count;
  int    check_count;
  bit    loaded;

  logic  op_q[$];
  addr_t addr_q[$];
  data_t wdata_q[$];
  strb_t strb_q[$];
  data_t exp_q[$];
  logic  err_q[$];
  logic  gap_q[$];

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  axi_sub_top uut (
    .clk      (clk),
    .rstn     (rstn),
    .read     (read),
    .write    (write),
    .addr     (addr),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .data_out (data_out),
    .stall    (stall),
    .bus_err  (bus_err)
  );

  tb_checker u_checker (
    .clk         (clk),
    .rstn        (rstn),
    .read        (read),
    .write       (write),
    .stall       (stall),
    .bus_err     (bus_err),
    .data_out    (data_out),
    .exp_data    (exp_data),
    .exp_err     (exp_err),
    .req_num     (req_num),
    .error_count (error_count),
    .check_count (check_count)
  );

  task automatic load_stimulus(output bit ok);
    int fd;
    int line_no;
    int fields;
    string line;
    logic [31:0] f_op, f_addr, f_data, f_strb, f_exp, f_err, f_gap;
    ok = 1'b1;
    line_no = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open %s", STIM_FILE);
      ok = 1'b0;
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        // Skip comments and blank lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h",
                           f_op, f_addr, f_data, f_strb, f_exp, f_err, f_gap);
          if (fields != 7) begin
            $display("ERROR: line %0d of %s has %0d fields instead of 7",
                     line_no, STIM_FILE, fields);
            ok = 1'b0;
          end else begin
            op_q.push_back(f_op != 0);
            addr_q.push_back(addr_t'(f_addr));
            wdata_q.push_back(data_t'(f_data));
            strb_q.push_back(strb_t'(f_strb));
            exp_q.push_back(data_t'(f_exp));
            err_q.push_back(f_err != 0);
            gap_q.push_back(f_gap != 0);
          end
        end
      end
      $fclose(fd);
      if (op_q.size() == 0) begin
        $display("ERROR: %s holds no requests", STIM_FILE);
        ok = 1'b0;
      end
    end
  endtask

  task automatic clear_request();
    read  = 1'b0;
    write = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
  endtask

  task automatic apply_request(input int k);
    write    = op_q[k];
    read     = !op_q[k];
    addr     = addr_q[k];
    wdata    = wdata_q[k];
    wstrb    = strb_q[k];
    exp_data = exp_q[k];
    exp_err  = err_q[k];
    req_num  = k;
  endtask

  // Request held until an edge sees stall low
  task automatic wait_for_completion();
    do begin
      @(posedge clk);
    end while (stall);
    #DRIVE_DELAY;
  endtask

  task automatic print_counts();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
  endtask

  initial begin : main
    bit ok;
    int seed;
    int gap;
    rstn     = 1'b0;
    exp_data = '0;
    exp_err  = 1'b0;
    req_num  = -1;
    loaded   = 1'b0;
    clear_request();
    seed = $urandom(19595);
    load_stimulus(ok);
    if (!ok) begin
      $display("ERROR: stimulus could not be loaded, no requests were run");
      $display("*** TEST FAILED ***");
    end else begin
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rstn = 1'b1;
      // A few quiet cycles right after reset
      repeat (3) @(posedge clk);
      #DRIVE_DELAY;
      for (int k = 0; k < op_q.size(); k++) begin
        if (gap_q[k]) begin
          clear_request();
          gap = 1 + $urandom_range(3, 0);
          repeat (gap) @(posedge clk);
          #DRIVE_DELAY;
        end
        apply_request(k);
        wait_for_completion();
      end
      clear_request();
      repeat (3) @(posedge clk);
      print_counts();
      if (error_count == 0 && check_count > 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = RESET_CYCLES + op_q.size() * CYCLES_PER_REQ;
    repeat (limit) @(posedge clk);
    $display("ERROR: run timed out after %0d cycles, a request never completed", limit);
    print_counts();
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== dv/axi_stimulus.txt ====
# op(0 read, 1 write) addr wdata strb exp_rdata exp_err gap(1 random idle cycles before)
# On a write line exp_rdata is the last completed read word that data_out must hold
1 00001000 deadbeef f 00000000 0 1
0 00001000 00000000 0 deadbeef 0 1
1 00001004 11223344 f deadbeef 0 1
1 00001004 aabbccdd 5 deadbeef 0 1
0 00001004 00000000 0 11bb33dd 0 1
1 000013fc cafef00d f 11bb33dd 0 0
0 000013fc 00000000 0 cafef00d 0 0
1 000013fc 0000a500 2 cafef00d 0 1
0 000013fc 00000000 0 cafea50d 0 0
0 00002000 00000000 0 00000000 1 1
0 00001000 00000000 0 deadbeef 0 0
1 00000ffc 12345678 f deadbeef 1 1
0 00001004 00000000 0 11bb33dd 0 0
1 00001400 87654321 f 11bb33dd 1 0
1 00001008 0badf00d f 11bb33dd 0 1
1 00001008 12345678 c 11bb33dd 0 0
0 00001008 00000000 0 1234f00d 0 1
0 00001000 00000000 0 deadbeef 0 1
0 00003000 00000000 0 00000000 1 1
1 00001000 00000000 0 00000000 0 1
0 00001000 00000000 0 deadbeef 0 0

// ==== flist.f ====
hw/axi_sub_pkg.sv
hw/bus_timer.sv
hw/axi_master.sv
hw/sram_slave.sv
hw/axi_sub_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== Bender.yml ====
package:
  name: axi_sub

sources:
  - files:
      - hw/axi_sub_pkg.sv
      - hw/bus_timer.sv
      - hw/axi_master.sv
      - hw/sram_slave.sv
      - hw/axi_sub_top.sv
  - target: test
    files:
      - dv/tb_checker.sv
      - dv/tb_top.sv
